/* design/ooo_pkg.sv */
`default_nettype none

package ooo_pkg;

    // operation encoding, two bits
    typedef enum logic [1:0] {
        op_add   = 2'd0,
        op_sub   = 2'd1,
        op_beq   = 2'd2,
        op_store = 2'd3
    } op_t;

    // operand and result width
    localparam int DATA_W = 32;

    // program counters and store addresses
    localparam int ADDR_W = 32;

    // register name, r0 means no write
    localparam int REG_W = 5;

    // reorder buffer
    localparam int ROB_DEPTH = 8;
    localparam int NICK_W    = 3;
    localparam int ROB_CNT_W = NICK_W + 1;

    // store buffer
    localparam int SB_DEPTH  = 4;
    localparam int SB_PTR_W  = 2;
    localparam int SB_CNT_W  = SB_PTR_W + 1;

    // sequential fetch step
    localparam int PC_STEP = 4;

endpackage

`default_nettype wire

/* design/rob.sv */
`default_nettype none

module rob (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       issue_en,
    input  ooo_pkg::op_t               issue_op,
    input  logic [ooo_pkg::REG_W-1:0]  issue_rd,
    input  logic                       issue_pred_taken,
    input  logic                       sb_full,
    output logic                       issue_full,

    output logic                       alloc_en,
    output logic [ooo_pkg::NICK_W-1:0] alloc_nick,

    input  logic                       ex_en,
    input  logic [ooo_pkg::NICK_W-1:0] ex_nick,
    input  logic [ooo_pkg::DATA_W-1:0] ex_data,
    input  logic                       ex_taken,
    input  logic [ooo_pkg::ADDR_W-1:0] ex_next_pc,

    output logic                       store_release,
    input  logic                       store_done,
    input  logic [ooo_pkg::NICK_W-1:0] store_done_nick,

    output logic                       commit_en,
    output logic [ooo_pkg::NICK_W-1:0] commit_nick,
    output logic [ooo_pkg::REG_W-1:0]  commit_rd,
    output logic [ooo_pkg::DATA_W-1:0] commit_data,

    output logic                       redirect_en,
    output logic [ooo_pkg::ADDR_W-1:0] redirect_pc,
    output logic                       flush
);
    import ooo_pkg::*;

    localparam logic [ROB_CNT_W-1:0] ROB_FULL = ROB_CNT_W'(ROB_DEPTH);

    // per-entry control flags
    logic [ROB_DEPTH-1:0] busy;
    logic [ROB_DEPTH-1:0] done;
    logic [ROB_DEPTH-1:0] sent;

    // per-entry payload
    logic              is_store  [ROB_DEPTH];
    logic              pred      [ROB_DEPTH];
    logic              taken     [ROB_DEPTH];
    logic [REG_W-1:0]  rd_q      [ROB_DEPTH];
    logic [DATA_W-1:0] data_q    [ROB_DEPTH];
    logic [ADDR_W-1:0] next_pc_q [ROB_DEPTH];

    logic [NICK_W-1:0]    head;
    logic [NICK_W-1:0]    tail;
    logic [ROB_CNT_W-1:0] count;

    logic rob_full;
    logic retire;

    assign rob_full = (count == ROB_FULL);

    assign issue_full = flush || rob_full || (issue_op == op_store && sb_full);

    assign alloc_en   = issue_en && !issue_full;
    assign alloc_nick = tail;

    // head is a finished non-store
    assign commit_en   = !flush && busy[head] && done[head] && !is_store[head];
    assign commit_nick = head;
    assign commit_rd   = rd_q[head];
    assign commit_data = data_q[head];

    // only beq entries can disagree, pred and taken are 0 for the rest
    assign redirect_en = commit_en && (taken[head] != pred[head]);
    assign redirect_pc = next_pc_q[head];

    assign store_release = !flush && busy[head] && is_store[head] && !sent[head];

    assign retire = commit_en || store_done;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy  <= '0;
            done  <= '0;
            sent  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end else if (flush) begin
            // squash everything younger than the mispredicted branch
            busy  <= '0;
            done  <= '0;
            sent  <= '0;
            head  <= '0;
            tail  <= '0;
            count <= '0;
            flush <= 1'b0;
        end else begin
            flush <= redirect_en;

            if (alloc_en) begin
                busy[tail] <= 1'b1;
                done[tail] <= 1'b0;
                sent[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end

            if (ex_en) begin
                done[ex_nick] <= 1'b1;
            end

            if (store_release) begin
                sent[head] <= 1'b1;
            end

            if (retire) begin
                busy[head] <= 1'b0;
                done[head] <= 1'b0;
                sent[head] <= 1'b0;
                head       <= head + 1'b1;
            end

            case ({alloc_en, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_en) begin
            is_store[tail] <= (issue_op == op_store);
            pred[tail]     <= issue_pred_taken && (issue_op == op_beq);
            rd_q[tail]     <= issue_rd;
        end
        if (ex_en) begin
            data_q[ex_nick]    <= ex_data;
            taken[ex_nick]     <= ex_taken;
            next_pc_q[ex_nick] <= ex_next_pc;
        end
    end

    // results only come back for live entries, and only once
    assert property (@(posedge clk) disable iff (!rst_n || flush)
        ex_en |-> (busy[ex_nick] && !done[ex_nick]));

    // store buffer drains in program order
    assert property (@(posedge clk) disable iff (!rst_n)
        store_done |-> (store_done_nick == head));

endmodule

`default_nettype wire

/* design/exec_alu.sv */
`default_nettype none

module exec_alu (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,

    input  logic                       alloc_en,
    input  logic [ooo_pkg::NICK_W-1:0] alloc_nick,

    input  ooo_pkg::op_t               issue_op,
    input  logic [ooo_pkg::ADDR_W-1:0] issue_pc,
    input  logic [ooo_pkg::DATA_W-1:0] issue_a,
    input  logic [ooo_pkg::DATA_W-1:0] issue_b,
    input  logic [ooo_pkg::ADDR_W-1:0] issue_target,

    output logic                       ex_en,
    output logic [ooo_pkg::NICK_W-1:0] ex_nick,
    output logic [ooo_pkg::DATA_W-1:0] ex_data,
    output logic                       ex_taken,
    output logic [ooo_pkg::ADDR_W-1:0] ex_next_pc
);
    import ooo_pkg::*;

    logic              take;
    logic              eq;
    logic              br_taken;
    logic [DATA_W-1:0] result;
    logic [ADDR_W-1:0] next_pc;

    // stores go to the store buffer instead
    assign take = alloc_en && (issue_op != op_store);

    assign eq       = (issue_a == issue_b);
    assign br_taken = (issue_op == op_beq) && eq;
    assign next_pc  = br_taken ? issue_target : issue_pc + ADDR_W'(PC_STEP);

    always_comb begin
        case (issue_op)
            op_add:  result = issue_a + issue_b;
            op_sub:  result = issue_a - issue_b;
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            ex_en <= 1'b0;
        end else begin
            ex_en <= take;
        end
    end

    // result stage payload
    always_ff @(posedge clk) begin
        if (take) begin
            ex_nick    <= alloc_nick;
            ex_data    <= result;
            ex_taken   <= br_taken;
            ex_next_pc <= next_pc;
        end
    end

    // nothing enters the result stage while flushing
    assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> !take);

endmodule

`default_nettype wire

/* design/store_buffer.sv */
`default_nettype none

module store_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       flush,

    input  logic                       alloc_en,
    input  logic [ooo_pkg::NICK_W-1:0] alloc_nick,

    input  ooo_pkg::op_t               issue_op,
    input  logic [ooo_pkg::DATA_W-1:0] issue_a,
    input  logic [ooo_pkg::DATA_W-1:0] issue_b,

    output logic                       sb_full,

    input  logic                       store_release,

    output logic                       mem_we,
    output logic [ooo_pkg::ADDR_W-1:0] mem_addr,
    output logic [ooo_pkg::DATA_W-1:0] mem_wdata,

    output logic                       store_done,
    output logic [ooo_pkg::NICK_W-1:0] store_done_nick
);
    import ooo_pkg::*;

    localparam logic [SB_CNT_W-1:0] SB_FULL = SB_CNT_W'(SB_DEPTH);

    // fifo storage
    logic [NICK_W-1:0] nick_q [SB_DEPTH];
    logic [ADDR_W-1:0] addr_q [SB_DEPTH];
    logic [DATA_W-1:0] data_q [SB_DEPTH];

    logic [SB_PTR_W-1:0] wr_ptr;
    logic [SB_PTR_W-1:0] rd_ptr;
    logic [SB_CNT_W-1:0] count;

    logic push;
    logic pop;

    assign push = alloc_en && (issue_op == op_store);
    assign pop  = store_release;

    assign sb_full = (count == SB_FULL);

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            nick_q[wr_ptr] <= alloc_nick;
            addr_q[wr_ptr] <= ADDR_W'(issue_a);
            data_q[wr_ptr] <= issue_b;
        end
    end

    // write strobe, one cycle after release
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_we <= 1'b0;
        end else begin
            mem_we <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            mem_addr        <= addr_q[rd_ptr];
            mem_wdata       <= data_q[rd_ptr];
            store_done_nick <= nick_q[rd_ptr];
        end
    end

    // done pulse is the memory write itself
    assign store_done = mem_we;

    assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !sb_full);

    assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> (count != '0));

endmodule

`default_nettype wire

/* design/ooo_core_top.sv */
`default_nettype none

module ooo_core_top (
    input  logic                       clk,
    input  logic                       rst_n,

    input  logic                       issue_en,
    input  ooo_pkg::op_t               issue_op,
    input  logic [ooo_pkg::ADDR_W-1:0] issue_pc,
    input  logic [ooo_pkg::REG_W-1:0]  issue_rd,
    input  logic [ooo_pkg::DATA_W-1:0] issue_a,
    input  logic [ooo_pkg::DATA_W-1:0] issue_b,
    input  logic                       issue_pred_taken,
    input  logic [ooo_pkg::ADDR_W-1:0] issue_target,
    output logic                       issue_full,

    output logic                       commit_en,
    output logic [ooo_pkg::NICK_W-1:0] commit_nick,
    output logic [ooo_pkg::REG_W-1:0]  commit_rd,
    output logic [ooo_pkg::DATA_W-1:0] commit_data,

    output logic                       redirect_en,
    output logic [ooo_pkg::ADDR_W-1:0] redirect_pc,

    output logic                       mem_we,
    output logic [ooo_pkg::ADDR_W-1:0] mem_addr,
    output logic [ooo_pkg::DATA_W-1:0] mem_wdata
);
    import ooo_pkg::*;

    logic              alloc_en;
    logic [NICK_W-1:0] alloc_nick;
    logic              flush;
    logic              sb_full;

    // alu result path
    logic              ex_en;
    logic [NICK_W-1:0] ex_nick;
    logic [DATA_W-1:0] ex_data;
    logic              ex_taken;
    logic [ADDR_W-1:0] ex_next_pc;

    // store release handshake
    logic              store_release;
    logic              store_done;
    logic [NICK_W-1:0] store_done_nick;

    rob u_rob (
        .clk              (clk),
        .rst_n            (rst_n),
        .issue_en         (issue_en),
        .issue_op         (issue_op),
        .issue_rd         (issue_rd),
        .issue_pred_taken (issue_pred_taken),
        .sb_full          (sb_full),
        .issue_full       (issue_full),
        .alloc_en         (alloc_en),
        .alloc_nick       (alloc_nick),
        .ex_en            (ex_en),
        .ex_nick          (ex_nick),
        .ex_data          (ex_data),
        .ex_taken         (ex_taken),
        .ex_next_pc       (ex_next_pc),
        .store_release    (store_release),
        .store_done       (store_done),
        .store_done_nick  (store_done_nick),
        .commit_en        (commit_en),
        .commit_nick      (commit_nick),
        .commit_rd        (commit_rd),
        .commit_data      (commit_data),
        .redirect_en      (redirect_en),
        .redirect_pc      (redirect_pc),
        .flush            (flush)
    );

    exec_alu u_exec_alu (
        .clk          (clk),
        .rst_n        (rst_n),
        .flush        (flush),
        .alloc_en     (alloc_en),
        .alloc_nick   (alloc_nick),
        .issue_op     (issue_op),
        .issue_pc     (issue_pc),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .issue_target (issue_target),
        .ex_en        (ex_en),
        .ex_nick      (ex_nick),
        .ex_data      (ex_data),
        .ex_taken     (ex_taken),
        .ex_next_pc   (ex_next_pc)
    );

    store_buffer u_store_buffer (
        .clk             (clk),
        .rst_n           (rst_n),
        .flush           (flush),
        .alloc_en        (alloc_en),
        .alloc_nick      (alloc_nick),
        .issue_op        (issue_op),
        .issue_a         (issue_a),
        .issue_b         (issue_b),
        .sb_full         (sb_full),
        .store_release   (store_release),
        .mem_we          (mem_we),
        .mem_addr        (mem_addr),
        .mem_wdata       (mem_wdata),
        .store_done      (store_done),
        .store_done_nick (store_done_nick)
    );

endmodule

`default_nettype wire

/* bench/tb_ooo_core.sv */
`default_nettype none

module tb_ooo_core;
    import ooo_pkg::*;

    localparam int ISSUE_TIMEOUT = 64;
    localparam int DRAIN_TIMEOUT = 256;

    typedef struct packed {
        op_t               op;
        logic [ADDR_W-1:0] pc;
        logic [REG_W-1:0]  rd;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic              pred;
        logic [ADDR_W-1:0] target;
        logic [NICK_W-1:0] nick;
    } inst_t;

    logic              clk;
    logic              rst_n;
    logic              issue_en;
    op_t               issue_op;
    logic [ADDR_W-1:0] issue_pc;
    logic [REG_W-1:0]  issue_rd;
    logic [DATA_W-1:0] issue_a;
    logic [DATA_W-1:0] issue_b;
    logic              issue_pred_taken;
    logic [ADDR_W-1:0] issue_target;
    logic              issue_full;
    logic              commit_en;
    logic [NICK_W-1:0] commit_nick;
    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;
    logic              redirect_en;
    logic [ADDR_W-1:0] redirect_pc;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [DATA_W-1:0] mem_wdata;

    ooo_core_top uut (
        .clk              (clk),
        .rst_n            (rst_n),
        .issue_en         (issue_en),
        .issue_op         (issue_op),
        .issue_pc         (issue_pc),
        .issue_rd         (issue_rd),
        .issue_a          (issue_a),
        .issue_b          (issue_b),
        .issue_pred_taken (issue_pred_taken),
        .issue_target     (issue_target),
        .issue_full       (issue_full),
        .commit_en        (commit_en),
        .commit_nick      (commit_nick),
        .commit_rd        (commit_rd),
        .commit_data      (commit_data),
        .redirect_en      (redirect_en),
        .redirect_pc      (redirect_pc),
        .mem_we           (mem_we),
        .mem_addr         (mem_addr),
        .mem_wdata        (mem_wdata)
    );

    // model of accepted, unretired instructions in program order
    inst_t             model_q [$];
    inst_t             head_inst;
    int                model_cnt;
    int                store_cnt;
    logic              head_sent;
    logic              in_flush;
    logic [NICK_W-1:0] nick_ctr;
    int                errors = 0;
    int                commits = 0;
    int                mem_writes = 0;
    logic [ADDR_W-1:0] pc;

    logic              head_store;
    logic              head_beq;
    logic              exp_mispredict;
    logic              exp_full;
    logic [REG_W-1:0]  exp_rd;
    logic [DATA_W-1:0] exp_data;
    logic [ADDR_W-1:0] exp_next_pc;

    function automatic logic [DATA_W-1:0] alu_result(input inst_t i);
        case (i.op)
            op_add:  return i.a + i.b;
            op_sub:  return i.a - i.b;
            default: return '0;
        endcase
    endfunction

    function automatic logic [ADDR_W-1:0] branch_next_pc(input inst_t i);
        return (i.a == i.b) ? i.target : i.pc + 32'd4;
    endfunction

    assign head_store     = (model_cnt != 0) && (head_inst.op == op_store);
    assign head_beq       = (model_cnt != 0) && (head_inst.op == op_beq);
    assign exp_mispredict = head_beq && (head_inst.pred != (head_inst.a == head_inst.b));
    assign exp_rd         = head_inst.rd;
    assign exp_data       = alu_result(head_inst);
    assign exp_next_pc    = branch_next_pc(head_inst);
    // stores still held in the store buffer
    assign exp_full = in_flush || (model_cnt == ROB_DEPTH) ||
                      (issue_op == op_store && (store_cnt - int'(head_sent)) == SB_DEPTH);

    task automatic report_mismatch(input string name, input logic [DATA_W-1:0] expected,
                                   input logic [DATA_W-1:0] actual);
        errors++;
        $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    always @(posedge clk) begin : reference_model
        inst_t             item;
        logic              sent_next;
        int                stores;
        logic [NICK_W-1:0] nick_next;
        if (!rst_n) begin
            model_q.delete();
            head_inst <= '0;
            model_cnt <= 0;
            store_cnt <= 0;
            head_sent <= 1'b0;
            in_flush  <= 1'b0;
            nick_ctr  <= '0;
        end else begin
            sent_next = head_sent;
            stores    = store_cnt;
            nick_next = nick_ctr;
            // a store leaves the buffer in its first cycle at the head
            if (model_q.size() != 0 && model_q[0].op == op_store && !in_flush) begin
                sent_next = 1'b1;
            end
            if ((commit_en || mem_we) && model_q.size() != 0) begin
                item = model_q.pop_front();
                if (item.op == op_store) begin
                    stores--;
                    mem_writes++;
                end else begin
                    commits++;
                end
                sent_next = 1'b0;
            end
            if (issue_en && !issue_full) begin
                item.op     = issue_op;
                item.pc     = issue_pc;
                item.rd     = issue_rd;
                item.a      = issue_a;
                item.b      = issue_b;
                item.pred   = issue_pred_taken;
                item.target = issue_target;
                item.nick   = nick_next;
                nick_next   = nick_next + 1'b1;
                model_q.push_back(item);
                if (issue_op == op_store) begin
                    stores++;
                end
            end
            // everything younger than the branch is gone
            if (redirect_en) begin
                model_q.delete();
                stores    = 0;
                sent_next = 1'b0;
                nick_next = '0;
            end
            if (model_q.size() != 0) begin
                head_inst <= model_q[0];
            end else begin
                head_inst <= '0;
            end
            model_cnt <= model_q.size();
            store_cnt <= stores;
            head_sent <= sent_next;
            in_flush  <= redirect_en;
            nick_ctr  <= nick_next;
        end
    end

    commit_order: assert property (@(posedge clk) disable iff (!rst_n)
        commit_en |-> (model_cnt != 0 && !head_store))
        else report_failure("commit while the oldest pending instruction is not an ALU op");

    commit_rd_check: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_en && model_cnt != 0) |-> (commit_rd == exp_rd))
        else report_mismatch("commit_rd", DATA_W'($sampled(exp_rd)),
                             DATA_W'($sampled(commit_rd)));

    commit_nick_check: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_en && model_cnt != 0) |-> (commit_nick == head_inst.nick))
        else report_mismatch("commit_nick", DATA_W'($sampled(head_inst.nick)),
                             DATA_W'($sampled(commit_nick)));

    commit_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_en && model_cnt != 0) |-> (commit_data == exp_data))
        else report_mismatch("commit_data", $sampled(exp_data), $sampled(commit_data));

    store_order: assert property (@(posedge clk) disable iff (!rst_n)
        mem_we |-> head_store)
        else report_failure("memory write before all older instructions retired");

    store_addr_check: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_we && head_store) |-> (mem_addr == head_inst.a))
        else report_mismatch("mem_addr", $sampled(head_inst.a), $sampled(mem_addr));

    store_data_check: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_we && head_store) |-> (mem_wdata == head_inst.b))
        else report_mismatch("mem_wdata", $sampled(head_inst.b), $sampled(mem_wdata));

    branch_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_en && head_beq) |-> (redirect_en == exp_mispredict))
        else report_mismatch("redirect_en", DATA_W'($sampled(exp_mispredict)),
                             DATA_W'($sampled(redirect_en)));

    redirect_source: assert property (@(posedge clk) disable iff (!rst_n)
        redirect_en |-> (commit_en && head_beq))
        else report_failure("redirect without a committing branch");

    redirect_target: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_en && head_beq) |-> (redirect_pc == exp_next_pc))
        else report_mismatch("redirect_pc", $sampled(exp_next_pc), $sampled(redirect_pc));

    flush_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        in_flush |-> (!commit_en && !mem_we))
        else report_failure("commit or memory write during the flush cycle");

    back_pressure: assert property (@(posedge clk) disable iff (!rst_n)
        issue_full == exp_full)
        else report_mismatch("issue_full", DATA_W'($sampled(exp_full)),
                             DATA_W'($sampled(issue_full)));

    // holds the instruction until accepted
    task automatic issue_inst(input op_t op, input logic [DATA_W-1:0] a,
                              input logic [DATA_W-1:0] b, input logic pred, output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        issue_en         <= 1'b1;
        issue_op         <= op;
        issue_pc         <= pc;
        issue_rd         <= REG_W'($urandom_range(31, 0));
        issue_a          <= a;
        issue_b          <= b;
        issue_pred_taken <= pred;
        issue_target     <= $urandom & 32'hffff_fffc;
        while (!ok && waited < ISSUE_TIMEOUT) begin
            @(posedge clk);
            if (!issue_full) begin
                ok = 1'b1;
            end else begin
                waited++;
            end
        end
        issue_en <= 1'b0;
        if (ok) begin
            pc = pc + 32'd4;
        end else begin
            report_failure("instruction not accepted before the timeout");
        end
    endtask

    task automatic issue_random(input logic allow_beq, output logic ok);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        int                sel;
        a   = $urandom;
        b   = $urandom;
        sel = int'($urandom_range(allow_beq ? 3 : 2, 0));
        case (sel)
            0:       issue_inst(op_add, a, b, 1'($urandom_range(1, 0)), ok);
            1:       issue_inst(op_sub, a, b, 1'($urandom_range(1, 0)), ok);
            2:       issue_inst(op_store, a, b, 1'b0, ok);
            default: begin
                if ($urandom_range(1, 0) == 1) begin
                    b = a;
                end
                issue_inst(op_beq, a, b, a == b, ok);
            end
        endcase
    endtask

    task automatic drain_core(output logic ok);
        int waited;
        waited = 0;
        ok = 1'b0;
        while (!ok && waited < DRAIN_TIMEOUT) begin
            @(posedge clk);
            if (model_cnt == 0 && !in_flush) begin
                ok = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!ok) begin
            report_failure("core did not drain before the timeout");
        end
    endtask

    task automatic run_tests();
        logic              ok;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        // mixed stream, branches predicted right
        for (int i = 0; i < 40; i++) begin
            issue_random(1'b1, ok);
            if (!ok) return;
        end
        drain_core(ok);
        if (!ok) return;
        a = $urandom;
        issue_inst(op_beq, a, a, 1'b1, ok);
        if (!ok) return;
        issue_inst(op_beq, a, a + 32'd1, 1'b0, ok);
        if (!ok) return;
        drain_core(ok);
        if (!ok) return;
        // wrong prediction in both directions, younger work flushed
        for (int r = 0; r < 4; r++) begin
            issue_inst(op_add, $urandom, $urandom, 1'b0, ok);
            if (!ok) return;
            issue_inst(op_store, $urandom, $urandom, 1'b0, ok);
            if (!ok) return;
            a = $urandom;
            b = (r % 2 == 0) ? a : $urandom;
            issue_inst(op_beq, a, b, a != b, ok);
            if (!ok) return;
            for (int j = 0; j < 6; j++) begin
                issue_random(1'b0, ok);
                if (!ok) return;
            end
            drain_core(ok);
            if (!ok) return;
        end
        // fill the store buffer, then the reorder buffer
        for (int i = 0; i < 8; i++) begin
            issue_inst(op_store, $urandom, $urandom, 1'b0, ok);
            if (!ok) return;
        end
        for (int i = 0; i < 12; i++) begin
            issue_inst(op_add, $urandom, $urandom, 1'b0, ok);
            if (!ok) return;
        end
        drain_core(ok);
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        void'($urandom(32'hca7e84d9));
        pc = 32'h0000_1000;
        rst_n            <= 1'b0;
        issue_en         <= 1'b0;
        issue_op         <= op_add;
        issue_pc         <= '0;
        issue_rd         <= '0;
        issue_a          <= '0;
        issue_b          <= '0;
        issue_pred_taken <= 1'b0;
        issue_target     <= '0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (!commit_en) else report_failure("commit_en high after reset");
        assert (!mem_we) else report_failure("mem_we high after reset");
        assert (!redirect_en) else report_failure("redirect_en high after reset");
        assert (!issue_full) else report_failure("issue_full high after reset");
        run_tests();
        $display("closing: %0d errors, %0d commits, %0d memory writes",
                 errors, commits, mem_writes);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
design/ooo_pkg.sv
design/rob.sv
design/exec_alu.sv
design/store_buffer.sv
design/ooo_core_top.sv
bench/tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_ooo_core \
    -f flist.f \
    -o sim_ooo_core

./obj_dir/sim_ooo_core | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
    exit 0
fi
exit 1
